/* design/cnn_cfg.svh */
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

`default_nettype none

// ------------------------------
// tile geometry
// ------------------------------

// lanes in the MAC row, also the width of one buffer bank
`define N_LANES 8

// signed activation and weight words
`define DATA_W 8

// sixteen buffer entries, two banks of N_LANES
`define PTR_W 4

// per-lane accumulator, saturating
`define ACC_W 24

// command field widths
`define SHIFT_W 4
`define STEP_W 6

`default_nettype wire

`endif

/* design/cnn_pkg.sv */
`include "cnn_cfg.svh"

`default_nettype none

package cnn_pkg;

	// layer modes, encoding shared with the rest of the tile
	typedef enum logic [1:0] {
		MODE_FC  = 2'd0,
		MODE_CNN = 2'd1,
		MODE_EWS = 2'd3
	} cnn_mode_e;

	typedef enum logic [2:0] {
		ST_IDLE    = 3'd0,
		ST_LOAD_LO = 3'd1,
		ST_LOAD_HI = 3'd2,
		ST_SHIFT   = 3'd3,
		ST_DONE    = 3'd4
	} loader_state_e;

	typedef logic signed [`DATA_W-1:0] act_word_t;
	typedef act_word_t [`N_LANES-1:0] act_vec_t;

	typedef logic signed [`ACC_W-1:0] acc_word_t;
	typedef acc_word_t [`N_LANES-1:0] acc_vec_t;

	typedef struct packed {
		cnn_mode_e mode;
		logic strided;
		logic phase;
		logic [`SHIFT_W-1:0] shift;
		logic [`STEP_W-1:0] steps;
		act_vec_t row_lo;
		act_vec_t row_hi;
	} tile_cmd_t;

	// loader to buffer control word
	typedef struct packed {
		logic clear;
		logic load;
		logic load_hi;
		logic shift_en;
		logic strided;
		logic phase;
		cnn_mode_e mode;
		logic [`SHIFT_W-1:0] shift;
	} buf_ctrl_t;

endpackage

`default_nettype wire

/* design/input_buffer.sv */
`include "cnn_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module input_buffer (
	input wire logic clk,
	input wire logic reset,
	input wire cnn_pkg::buf_ctrl_t ctrl,
	input wire cnn_pkg::act_vec_t parallel_in,
	input wire cnn_pkg::act_vec_t serial_in,
	output cnn_pkg::act_vec_t window
);

	localparam int LANES = `N_LANES;
	localparam int DEPTH = 2 * `N_LANES;

	// keeps an index inside bank 0
	localparam logic [`PTR_W-1:0] LANE_MASK = `PTR_W'(`N_LANES - 1);

	cnn_pkg::act_word_t mem [DEPTH];
	logic [`PTR_W-1:0] ptr;

	logic [`PTR_W-1:0] ptr_sum;
	logic [`PTR_W-1:0] ptr_next;
	logic [`PTR_W-1:0] wr_idx [LANES];
	logic [`PTR_W-1:0] rd_idx [LANES];
	logic cnn_mode;

	assign cnn_mode = (ctrl.mode == cnn_pkg::MODE_CNN);

	// ------------------------------
	// index arithmetic
	// ------------------------------

	// strided view wraps over all sixteen entries, plain view over bank 0
	always_comb begin
		ptr_sum = ptr + `PTR_W'(ctrl.shift);
		ptr_next = ctrl.strided ? ptr_sum : (ptr_sum & LANE_MASK);
		for (int i = 0; i < LANES; i++) begin
			wr_idx[i] = ptr + `PTR_W'(i);
			if (!ctrl.strided)
				wr_idx[i] = wr_idx[i] & LANE_MASK;
		end
	end

	// even phase reads ptr, ptr+2, ...; odd phase is one entry further
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			if (ctrl.strided)
				rd_idx[i] = ptr + `PTR_W'(2 * i) + `PTR_W'(ctrl.phase);
			else
				rd_idx[i] = (ptr + `PTR_W'(i)) & LANE_MASK;
		end
	end

	// ------------------------------
	// storage and pointer
	// ------------------------------

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int k = 0; k < DEPTH; k++)
				mem[k] <= '0;
			ptr <= '0;
		end else if (cnn_mode) begin
			if (ctrl.clear) begin
				for (int k = 0; k < DEPTH; k++)
					mem[k] <= '0;
				ptr <= '0;
			end
			// a load on the clear cycle overrides the zeroed bank
			if (ctrl.load) begin
				for (int i = 0; i < LANES; i++) begin
					if (ctrl.load_hi)
						mem[LANES + i] <= parallel_in[i];
					else
						mem[i] <= parallel_in[i];
				end
				ptr <= '0;
			end else if (ctrl.shift_en) begin
				// only the first shift lanes of the stream word are new
				for (int j = 0; j < LANES; j++) begin
					if (j < int'(ctrl.shift))
						mem[wr_idx[j]] <= serial_in[j];
				end
				ptr <= ptr_next;
			end
		end
	end

	// ------------------------------
	// window select
	// ------------------------------

	always_comb begin
		window = parallel_in;
		if (cnn_mode) begin
			for (int i = 0; i < LANES; i++)
				window[i] = mem[rd_idx[i]];
		end
	end

	// fc and ews keep the buffer untouched
	// so the sliding state carries over

	// ------------------------------
	// checks
	// ------------------------------

	a_shift_range: assert property (
		@(posedge clk) disable iff (!reset)
		ctrl.shift_en |-> (ctrl.shift <= `SHIFT_W'(`N_LANES))
	) else $error("input_buffer: shift amount %0d above lane count", ctrl.shift);

	a_load_xor_shift: assert property (
		@(posedge clk) disable iff (!reset)
		!(ctrl.load && ctrl.shift_en)
	) else $error("input_buffer: load and shift in the same cycle");

endmodule

`default_nettype wire

/* design/tile_loader.sv */
`include "cnn_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module tile_loader (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire cnn_pkg::tile_cmd_t cmd,
	output cnn_pkg::buf_ctrl_t ctrl,
	output cnn_pkg::act_vec_t parallel_out,
	output logic stream_take,
	output logic window_valid,
	output logic tile_begin,
	output logic busy,
	output logic done
);

	cnn_pkg::loader_state_e state;
	cnn_pkg::tile_cmd_t cmd_q;
	logic [`STEP_W-1:0] step_cnt;
	logic accept;
	logic is_cnn;

	assign accept = start && (state == cnn_pkg::ST_IDLE);
	assign is_cnn = (cmd_q.mode == cnn_pkg::MODE_CNN);

	// command held for the whole tile
	always_ff @(posedge clk) begin
		if (accept)
			cmd_q <= cmd;
	end

	// ------------------------------
	// sequencer
	// ------------------------------

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= cnn_pkg::ST_IDLE;
			step_cnt <= '0;
		end else begin
			case (state)
				cnn_pkg::ST_IDLE: begin
					if (accept) begin
						state <= cnn_pkg::ST_LOAD_LO;
						step_cnt <= cmd.steps;
					end
				end
				cnn_pkg::ST_LOAD_LO: state <= cnn_pkg::ST_LOAD_HI;
				cnn_pkg::ST_LOAD_HI: state <= cnn_pkg::ST_SHIFT;
				cnn_pkg::ST_SHIFT: begin
					if (step_cnt <= `STEP_W'(1))
						state <= cnn_pkg::ST_DONE;
					else
						step_cnt <= step_cnt - `STEP_W'(1);
				end
				cnn_pkg::ST_DONE: state <= cnn_pkg::ST_IDLE;
				default: state <= cnn_pkg::ST_IDLE;
			endcase
		end
	end

	// ------------------------------
	// buffer controls
	// ------------------------------

	always_comb begin
		ctrl = '0;
		ctrl.strided = cmd_q.strided;
		ctrl.phase = cmd_q.phase;
		ctrl.mode = cmd_q.mode;
		ctrl.shift = cmd_q.shift;
		case (state)
			cnn_pkg::ST_LOAD_LO: begin
				ctrl.clear = is_cnn;
				ctrl.load = is_cnn;
			end
			// plain mode reloads bank 0, which also resets the pointer
			cnn_pkg::ST_LOAD_HI: begin
				ctrl.load = is_cnn;
				ctrl.load_hi = cmd_q.strided;
			end
			cnn_pkg::ST_SHIFT: ctrl.shift_en = is_cnn;
			default: ;
		endcase
	end

	// row_hi only on the second load of a strided tile
	assign parallel_out = (state == cnn_pkg::ST_LOAD_HI && cmd_q.strided) ?
		cmd_q.row_hi : cmd_q.row_lo;

	assign window_valid = (state == cnn_pkg::ST_SHIFT);
	assign stream_take = (state == cnn_pkg::ST_SHIFT) && is_cnn;
	assign tile_begin = (state == cnn_pkg::ST_LOAD_LO);
	assign busy = (state != cnn_pkg::ST_IDLE);
	assign done = (state == cnn_pkg::ST_DONE);

	a_steps_nonzero: assert property (
		@(posedge clk) disable iff (!reset)
		accept |=> (cmd_q.steps != '0)
	) else $error("tile_loader: accepted a command with zero steps");

endmodule

`default_nettype wire

/* design/mac_row.sv */
`include "cnn_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module mac_row (
	input wire logic clk,
	input wire logic reset,
	input wire logic tile_begin,
	input wire logic window_valid,
	input wire cnn_pkg::act_vec_t window,
	input wire cnn_pkg::act_vec_t weights,
	output cnn_pkg::acc_vec_t acc
);

	localparam int LANES = `N_LANES;
	localparam int PROD_W = 2 * `DATA_W;
	localparam int SUM_W = `ACC_W + 1;

	localparam cnn_pkg::acc_word_t ACC_MAX = {1'b0, {(`ACC_W - 1){1'b1}}};
	localparam cnn_pkg::acc_word_t ACC_MIN = {1'b1, {(`ACC_W - 1){1'b0}}};

	logic signed [2*`DATA_W-1:0] prod [LANES];
	logic signed [`ACC_W:0] sum_ext [LANES];
	cnn_pkg::acc_vec_t acc_next;

	// one guard bit catches the overflow
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			prod[i] = PROD_W'(window[i]) * PROD_W'(weights[i]);
			sum_ext[i] = SUM_W'(acc[i]) + SUM_W'(prod[i]);
			if (sum_ext[i][`ACC_W] != sum_ext[i][`ACC_W-1])
				acc_next[i] = sum_ext[i][`ACC_W] ? ACC_MIN : ACC_MAX;
			else
				acc_next[i] = sum_ext[i][`ACC_W-1:0];
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			acc <= '0;
		else if (tile_begin)
			acc <= '0;
		else if (window_valid)
			acc <= acc_next;
	end

endmodule

`default_nettype wire

/* design/input_stage_top.sv */
`include "cnn_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module input_stage_top (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire cnn_pkg::tile_cmd_t cmd,
	input wire cnn_pkg::act_vec_t stream_data,
	input wire cnn_pkg::act_vec_t weights,
	output logic busy,
	output logic stream_take,
	output cnn_pkg::act_vec_t window,
	output logic window_valid,
	output cnn_pkg::acc_vec_t acc,
	output logic done
);

	cnn_pkg::buf_ctrl_t buf_ctrl;
	cnn_pkg::act_vec_t parallel_vec;
	logic tile_begin;

	tile_loader u_loader (
		.clk(clk),
		.reset(reset),
		.start(start),
		.cmd(cmd),
		.ctrl(buf_ctrl),
		.parallel_out(parallel_vec),
		.stream_take(stream_take),
		.window_valid(window_valid),
		.tile_begin(tile_begin),
		.busy(busy),
		.done(done)
	);

	input_buffer u_buffer (
		.clk(clk),
		.reset(reset),
		.ctrl(buf_ctrl),
		.parallel_in(parallel_vec),
		.serial_in(stream_data),
		.window(window)
	);

	mac_row u_mac (
		.clk(clk),
		.reset(reset),
		.tile_begin(tile_begin),
		.window_valid(window_valid),
		.window(window),
		.weights(weights),
		.acc(acc)
	);

endmodule

`default_nettype wire

/* testbench/input_stage_checker.sv */
`include "cnn_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module input_stage_checker (
	input wire logic clk,
	input wire logic reset,
	input wire logic armed,
	input wire logic busy,
	input wire logic stream_take,
	input wire logic window_valid,
	input wire logic done,
	input wire cnn_pkg::act_vec_t window,
	input wire cnn_pkg::acc_vec_t acc,
	input wire cnn_pkg::act_vec_t exp_win [64],
	input wire cnn_pkg::acc_vec_t exp_acc,
	input wire logic [6:0] exp_steps,
	input wire logic exp_cnn
);

	int errors = 0;
	int step;
	int busy_cnt;
	logic want_done;

	// outputs are sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin
		if (!reset || !armed) begin
			step = 0;
			busy_cnt = 0;
			want_done = 1'b0;
			if (reset && (window_valid || done || stream_take)) begin
				$display("window_valid, stream_take or done high with no tile running");
				errors++;
			end
		end else begin
			if (busy)
				busy_cnt++;
			if (want_done && !done) begin
				$display("done missing in the cycle after the last window");
				errors++;
				want_done = 1'b0;
			end
			if (done && !want_done) begin
				$display("done arrived before the window cycles were complete");
				errors++;
			end
			if (done) begin
				want_done = 1'b0;
				for (int i = 0; i < `N_LANES; i++) begin
					if (acc[i] !== exp_acc[i]) begin
						$display("Fail acc[%0d]: got %h expected %h", i, acc[i], exp_acc[i]);
						errors++;
					end
				end
				if (busy_cnt != int'(exp_steps) + 3) begin
					$display("Fail busy_cycles: got %h expected %h",
						busy_cnt, int'(exp_steps) + 3);
					errors++;
				end
			end
			if (window_valid) begin
				if (step >= int'(exp_steps)) begin
					$display("window_valid lasted longer than the step count");
					errors++;
				end else begin
					if (window !== exp_win[step]) begin
						$display("Fail window step %0d: got %h expected %h",
							step, window, exp_win[step]);
						errors++;
					end
					if (stream_take !== exp_cnn) begin
						$display("Fail stream_take step %0d: got %h expected %h",
							step, stream_take, exp_cnn);
						errors++;
					end
				end
				step++;
				if (step == int'(exp_steps))
					want_done = 1'b1;
			end else if (stream_take) begin
				$display("stream_take high outside a window cycle");
				errors++;
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_input_stage.sv */
`include "cnn_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module tb_input_stage;

	localparam int N_TILES = 16;

	logic clk;
	logic reset;
	logic start;
	cnn_pkg::tile_cmd_t cmd;
	cnn_pkg::act_vec_t stream_data;
	cnn_pkg::act_vec_t weights;
	logic busy;
	logic stream_take;
	cnn_pkg::act_vec_t window;
	logic window_valid;
	cnn_pkg::acc_vec_t acc;
	logic done;

	logic armed;
	cnn_pkg::act_vec_t exp_win [64];
	cnn_pkg::acc_vec_t exp_acc;
	logic [6:0] exp_steps;
	logic exp_cnn;

	cnn_pkg::tile_cmd_t cmds [N_TILES];
	cnn_pkg::act_vec_t words [N_TILES][64];
	cnn_pkg::act_vec_t wts [N_TILES];
	int cycles;
	int limit = 1000000;
	int tb_errors = 0;
	int total;

	input_stage_top u_dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.cmd(cmd),
		.stream_data(stream_data),
		.weights(weights),
		.busy(busy),
		.stream_take(stream_take),
		.window(window),
		.window_valid(window_valid),
		.acc(acc),
		.done(done)
	);

	input_stage_checker u_chk (
		.clk(clk),
		.reset(reset),
		.armed(armed),
		.busy(busy),
		.stream_take(stream_take),
		.window_valid(window_valid),
		.done(done),
		.window(window),
		.acc(acc),
		.exp_win(exp_win),
		.exp_acc(exp_acc),
		.exp_steps(exp_steps),
		.exp_cnn(exp_cnn)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------
	// reference model
	// ------------------------------

	function automatic void ref_model(input cnn_pkg::tile_cmd_t c,
		input cnn_pkg::act_vec_t sw [64], input cnn_pkg::act_vec_t w,
		output cnn_pkg::act_vec_t ew [64], output cnn_pkg::acc_vec_t ea);
		cnn_pkg::act_word_t mem [16];
		longint s [`N_LANES];
		int p;
		int depth;
		int idx;
		logic cnn;
		cnn = (c.mode == cnn_pkg::MODE_CNN);
		depth = c.strided ? 16 : 8;
		p = 0;
		for (int k = 0; k < 16; k++)
			mem[k] = '0;
		for (int i = 0; i < `N_LANES; i++) begin
			s[i] = 0;
			mem[i] = c.row_lo[i];
			if (c.strided)
				mem[8 + i] = c.row_hi[i];
		end
		for (int t = 0; t < 64; t++)
			ew[t] = '0;
		for (int t = 0; t < int'(c.steps); t++) begin
			for (int i = 0; i < `N_LANES; i++) begin
				if (!cnn)
					ew[t][i] = c.row_lo[i];
				else begin
					idx = c.strided ? (p + 2 * i + int'(c.phase)) % 16 : (p + i) % 8;
					ew[t][i] = mem[idx];
				end
				s[i] = s[i] + longint'(ew[t][i]) * longint'(w[i]);
				if (s[i] > 64'sd8388607)
					s[i] = 64'sd8388607;
				if (s[i] < -64'sd8388608)
					s[i] = -64'sd8388608;
			end
			if (cnn) begin
				for (int j = 0; j < int'(c.shift); j++)
					mem[(p + j) % depth] = sw[t][j];
				p = (p + int'(c.shift)) % depth;
			end
		end
		for (int i = 0; i < `N_LANES; i++)
			ea[i] = cnn_pkg::acc_word_t'(s[i]);
	endfunction

	// ------------------------------
	// stimulus helpers
	// ------------------------------

	function automatic cnn_pkg::act_vec_t rand_vec();
		cnn_pkg::act_vec_t v;
		for (int i = 0; i < `N_LANES; i++)
			v[i] = cnn_pkg::act_word_t'($urandom);
		return v;
	endfunction

	function automatic cnn_pkg::act_vec_t fill_vec(input int val);
		cnn_pkg::act_vec_t v;
		for (int i = 0; i < `N_LANES; i++)
			v[i] = cnn_pkg::act_word_t'(val);
		return v;
	endfunction

	function automatic cnn_pkg::tile_cmd_t make_cmd(input cnn_pkg::cnn_mode_e m,
		input logic strided, input logic phase, input int shift, input int steps);
		cnn_pkg::tile_cmd_t c;
		c.mode = m;
		c.strided = strided;
		c.phase = phase;
		c.shift = `SHIFT_W'(shift);
		c.steps = `STEP_W'(steps);
		c.row_lo = rand_vec();
		c.row_hi = rand_vec();
		return c;
	endfunction

	task automatic launch_tile(input int n);
		ref_model(cmds[n], words[n], wts[n], exp_win, exp_acc);
		exp_steps = 7'(cmds[n].steps);
		exp_cnn = (cmds[n].mode == cnn_pkg::MODE_CNN);
		@(posedge clk);
		start <= 1'b1;
		cmd <= cmds[n];
		weights <= wts[n];
		stream_data <= words[n][0];
		armed <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// poke sends a second start while the tile is busy
	task automatic run_tile(input int n, input bit poke);
		int k;
		logic take;
		logic fin;
		launch_tile(n);
		k = 0;
		do begin
			@(negedge clk);
			take = stream_take;
			fin = done;
			@(posedge clk);
			if (take) begin
				k++;
				if (k < 64)
					stream_data <= words[n][k];
			end
			start <= poke && take && (k == 2);
			cmd <= cmds[8];
		end while (!fin);
		start <= 1'b0;
		armed <= 1'b0;
	endtask

	task automatic check_low(input string name, input logic got);
		if (got !== 1'b0) begin
			$display("Fail %s: got %h expected %h", name, got, 1'b0);
			tb_errors++;
		end
	endtask

	task automatic reset_mid_tile(input int n);
		launch_tile(n);
		repeat (3) @(posedge clk);
		armed <= 1'b0;
		reset <= 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		check_low("busy", busy);
		check_low("done", done);
		check_low("stream_take", stream_take);
		check_low("window_valid", window_valid);
		if (acc !== '0) begin
			$display("Fail acc: got %h expected %h", acc, cnn_pkg::acc_vec_t'(0));
			tb_errors++;
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		void'($urandom(90));
		reset = 1'b0;
		start = 1'b0;
		cmd = '0;
		stream_data = '0;
		weights = '0;
		armed = 1'b0;
		exp_acc = '0;
		exp_steps = '0;
		exp_cnn = 1'b0;
		for (int t = 0; t < 64; t++)
			exp_win[t] = '0;

		for (int n = 0; n < N_TILES; n++) begin
			for (int t = 0; t < 64; t++)
				words[n][t] = rand_vec();
			wts[n] = rand_vec();
			cmds[n] = make_cmd(cnn_pkg::MODE_CNN, 1'b0, 1'b0,
				int'($urandom_range(8)), int'($urandom_range(20, 1)));
		end
		cmds[5] = make_cmd(cnn_pkg::MODE_CNN, 1'b1, 1'b0, int'($urandom_range(8, 1)), 14);
		cmds[6] = make_cmd(cnn_pkg::MODE_CNN, 1'b1, 1'b1, int'($urandom_range(8, 1)), 14);
		cmds[7] = make_cmd(cnn_pkg::MODE_CNN, 1'b1, 1'($urandom), 8, 10);
		cmds[8] = make_cmd(cnn_pkg::MODE_FC, 1'b0, 1'b0, 3, 6);
		cmds[9] = make_cmd(cnn_pkg::MODE_EWS, 1'b1, 1'b1, 5, 9);
		cmds[10] = make_cmd(cnn_pkg::MODE_CNN, 1'b0, 1'b0, 8, 63);
		cmds[11] = make_cmd(cnn_pkg::MODE_CNN, 1'b0, 1'b0, 8, 63);
		cmds[12] = make_cmd(cnn_pkg::MODE_CNN, 1'b0, 1'b0, 3, 7);
		cmds[13] = make_cmd(cnn_pkg::MODE_CNN, 1'b0, 1'b0, 4, 20);
		cmds[15] = make_cmd(cnn_pkg::MODE_CNN, 1'b1, 1'b1, 7, 12);

		// extreme operands for the accumulators
		cmds[10].row_lo = fill_vec(-128);
		cmds[11].row_lo = fill_vec(127);
		wts[10] = fill_vec(-128);
		wts[11] = fill_vec(-128);
		for (int t = 0; t < 64; t++) begin
			words[10][t] = fill_vec(-128);
			words[11][t] = fill_vec(127);
		end

		limit = 200;
		for (int n = 0; n < N_TILES; n++)
			limit += int'(cmds[n].steps) + 4;

		repeat (2) @(posedge clk);
		reset <= 1'b1;

		for (int n = 0; n < 13; n++)
			run_tile(n, n == 12);
		reset_mid_tile(13);
		run_tile(14, 1'b0);
		run_tile(15, 1'b0);
		repeat (2) @(posedge clk);

		total = tb_errors + u_chk.errors;
		$display("errors: checker %0d, testbench %0d", u_chk.errors, tb_errors);
		if (total == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles <= limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, a tile never finished", cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/cnn_pkg.sv
design/input_buffer.sv
design/tile_loader.sv
design/mac_row.sv
design/input_stage_top.sv
testbench/input_stage_checker.sv
testbench/tb_input_stage.sv

/* Makefile */
# Verilator simulation of the activation input stage

TOP = tb_input_stage

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
